//--- Bender.yml
package:
  name: acc_cpu

sources:
  - logic/core_pkg.sv
  - logic/isa_pkg.sv
  - logic/program_rom.sv
  - logic/cpu_decode.sv
  - logic/cpu_execute.sv
  - logic/data_ram.sv
  - logic/cpu_writeback.sv
  - logic/cpu_top.sv
  - target: test
    files:
      - test/tb_cpu_top.sv

//--- logic/core_pkg.sv
package core_pkg;

  localparam int DATA_W     = 8;  // Datapath width
  localparam int ROM_ADDR_W = 8;  // PC and ROM address width

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [ROM_ADDR_W-1:0] rom_addr_t;

  // Status flags, registered in writeback
  typedef struct packed {
    logic z;  // Result zero
    logic n;  // Result bit 7
    logic c;  // Carry, borrow or shifted-out bit
    logic v;  // Signed overflow
  } flags_t;

  // Byte shown on the display
  typedef enum logic [1:0] {
    VIEW_PC  = 2'd0,
    VIEW_A   = 2'd1,
    VIEW_B   = 2'd2,
    VIEW_ALU = 2'd3
  } view_e;

endpackage

//--- logic/cpu_decode.sv
module cpu_decode import core_pkg::*, isa_pkg::*; (
  input  instr_t instr,
  input  flags_t flags,
  output ctrl_t  ctrl
);

  always_comb begin
    // NOP passes A through the ALU and writes nothing
    ctrl          = '0;
    ctrl.alu_op   = ALU_ADD;
    ctrl.src_a    = SRC_A_REG;
    ctrl.src_b    = SRC_B_ZERO;
    case (instr.opcode)
      LDA_IMM: begin
        ctrl.src_a  = SRC_A_ZERO;  // 0 + imm
        ctrl.src_b  = SRC_B_IMM;
        ctrl.load_a = 1'b1;
      end
      LDB_IMM: begin
        ctrl.src_a  = SRC_A_ZERO;
        ctrl.src_b  = SRC_B_IMM;
        ctrl.load_b = 1'b1;  // Only opcode writing B
      end
      ADD, SUB, AND, OR, NOT, XOR, SHL, SHR: begin
        ctrl.src_b    = SRC_B_REG;
        ctrl.load_a   = 1'b1;
        ctrl.flags_en = 1'b1;
        case (instr.opcode)
          SUB:     ctrl.alu_op = ALU_SUB;
          AND:     ctrl.alu_op = ALU_AND;
          OR:      ctrl.alu_op = ALU_OR;
          NOT:     ctrl.alu_op = ALU_NOT;
          XOR:     ctrl.alu_op = ALU_XOR;
          SHL:     ctrl.alu_op = ALU_SHL;
          SHR:     ctrl.alu_op = ALU_SHR;
          default: ctrl.alu_op = ALU_ADD;
        endcase
      end
      ST:  ctrl.ram_we = 1'b1;  // A + 0 onto the write data
      LD: begin
        ctrl.src_a  = SRC_A_ZERO;  // 0 + mem[B]
        ctrl.src_b  = SRC_B_RAM;
        ctrl.load_a = 1'b1;
      end
      JMP: ctrl.jump = 1'b1;
      JZ:  ctrl.jump = flags.z;   // Condition on registered flags
      JNZ: ctrl.jump = ~flags.z;
      JN:  ctrl.jump = flags.n;
      JC:  ctrl.jump = flags.c;
      default: ;  // Unknown opcode behaves as NOP
    endcase
  end

  // A store never redirects the PC in the same step
  always_comb begin
    assert final (!(ctrl.ram_we && ctrl.jump))
      else $error("decode: store and jump together, opcode %h", instr.opcode);
  end

endmodule

//--- logic/cpu_execute.sv
module cpu_execute import core_pkg::*, isa_pkg::*; (
  input  ctrl_t  ctrl,
  input  data_t  reg_a,
  input  data_t  reg_b,
  input  data_t  ram_rdata,
  input  data_t  imm,
  output data_t  result,
  output flags_t next_flags
);

  data_t       op_a;
  data_t       op_b;
  logic [8:0]  sum;   // Bit 8 is carry out
  logic [8:0]  diff;  // Bit 8 is borrow

  // Operand selection
  always_comb begin
    op_a = (ctrl.src_a == SRC_A_ZERO) ? '0 : reg_a;
    case (ctrl.src_b)
      SRC_B_REG: op_b = reg_b;
      SRC_B_RAM: op_b = ram_rdata;
      SRC_B_IMM: op_b = imm;
      default:   op_b = '0;
    endcase
  end

  assign sum  = {1'b0, op_a} + {1'b0, op_b};
  assign diff = {1'b0, op_a} - {1'b0, op_b};

  always_comb begin
    next_flags = '0;
    case (ctrl.alu_op)
      ALU_ADD: begin
        result       = sum[7:0];
        next_flags.c = sum[8];
        next_flags.v = (op_a[7] == op_b[7]) && (sum[7] != op_a[7]);
      end
      ALU_SUB: begin
        result       = diff[7:0];
        next_flags.c = diff[8];  // Set when op_a < op_b
        next_flags.v = (op_a[7] != op_b[7]) && (diff[7] != op_a[7]);
      end
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_NOT: result = ~op_a;
      ALU_XOR: result = op_a ^ op_b;
      ALU_SHL: begin
        result       = {op_a[6:0], 1'b0};
        next_flags.c = op_a[7];  // Bit shifted out
      end
      default: begin  // ALU_SHR
        result       = {1'b0, op_a[7:1]};
        next_flags.c = op_a[0];
      end
    endcase
    next_flags.z = (result == '0);
    next_flags.n = result[7];
  end

endmodule

//--- logic/cpu_top.sv
module cpu_top import core_pkg::*, isa_pkg::*; #(
  parameter int RAM_DEPTH = 32
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  step,     // One instruction per strobe
  input  view_e view,
  output data_t display
);

  rom_addr_t pc;
  instr_t    instr;
  ctrl_t     ctrl;
  flags_t    flags;
  flags_t    next_flags;
  data_t     reg_a;
  data_t     reg_b;
  data_t     result;
  data_t     ram_rdata;
  logic      ram_we;

  program_rom u_program_rom (
    .addr  (pc),
    .instr (instr)
  );

  cpu_decode u_cpu_decode (
    .instr (instr),
    .flags (flags),
    .ctrl  (ctrl)
  );

  cpu_execute u_cpu_execute (
    .ctrl       (ctrl),
    .reg_a      (reg_a),
    .reg_b      (reg_b),
    .ram_rdata  (ram_rdata),
    .imm        (instr.imm),
    .result     (result),
    .next_flags (next_flags)
  );

  // Address from B, write data is A through the ALU
  data_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_data_ram (
    .clk   (clk),
    .rst   (rst),
    .we    (ram_we),
    .addr  (reg_b),
    .wdata (result),
    .rdata (ram_rdata)
  );

  cpu_writeback u_cpu_writeback (
    .clk         (clk),
    .rst         (rst),
    .step        (step),
    .ctrl        (ctrl),
    .result      (result),
    .next_flags  (next_flags),
    .jump_target (instr.imm),  // Immediate doubles as target
    .pc          (pc),
    .reg_a       (reg_a),
    .reg_b       (reg_b),
    .flags       (flags),
    .ram_we      (ram_we)
  );

  // Display view, purely combinational
  always_comb begin
    case (view)
      VIEW_PC:  display = pc;
      VIEW_A:   display = reg_a;
      VIEW_B:   display = reg_b;
      default:  display = result;  // ALU output of current instruction
    endcase
  end

endmodule

//--- logic/cpu_writeback.sv
module cpu_writeback import core_pkg::*, isa_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      step,
  input  ctrl_t     ctrl,
  input  data_t     result,
  input  flags_t    next_flags,
  input  rom_addr_t jump_target,
  output rom_addr_t pc,
  output data_t     reg_a,
  output data_t     reg_b,
  output flags_t    flags,
  output logic      ram_we
);

  rom_addr_t pc_next;

  assign pc_next = ctrl.jump ? jump_target : pc + 1'b1;
  assign ram_we  = step & ctrl.ram_we;  // RAM commits with the registers

  // Architectural state, advances one instruction per step
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc    <= '0;
      reg_a <= '0;
      reg_b <= '0;
      flags <= '0;
    end else if (step) begin
      pc <= pc_next;
      if (ctrl.load_a) begin
        reg_a <= result;
      end
      if (ctrl.load_b) begin
        reg_b <= result;
      end
      if (ctrl.flags_en) begin
        flags <= next_flags;  // ALU opcodes only
      end
    end
  end

  // Idle cycles hold the PC
  a_pc_hold: assert property (@(posedge clk) disable iff (rst) !step |=> $stable(pc))
    else $error("writeback: PC moved without step");

endmodule

//--- logic/data_ram.sv
module data_ram import core_pkg::*; #(
  parameter int RAM_DEPTH = 32
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  we,     // Already qualified by step
  input  data_t addr,
  input  data_t wdata,
  output data_t rdata
);

  localparam int AW = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

  data_t         mem [RAM_DEPTH];
  logic [AW-1:0] idx;  // Low address bits only

  assign idx = addr[AW-1:0];

  // Whole array clears so LD after reset reads zero
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < RAM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[idx] <= wdata;
    end
  end

  assign rdata = mem[idx];  // Same-cycle read for LD

  a_we_known: assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown({idx, wdata}))
    else $error("data_ram: write with unknown address or data");

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

  // Opcode field of the 15-bit instruction word
  typedef enum logic [6:0] {
    NOP     = 7'h00,
    LDA_IMM = 7'h02,  // A = imm
    LDB_IMM = 7'h03,  // B = imm
    ADD     = 7'h04,
    SUB     = 7'h06,
    AND     = 7'h08,
    OR      = 7'h0a,
    NOT     = 7'h0c,  // A = ~A
    XOR     = 7'h0e,
    SHL     = 7'h10,
    SHR     = 7'h12,
    ST      = 7'h14,  // mem[B] = A
    LD      = 7'h16,  // A = mem[B]
    JMP     = 7'h40,
    JZ      = 7'h41,
    JNZ     = 7'h42,
    JN      = 7'h43,
    JC      = 7'h44
  } opcode_e;

  typedef struct packed {
    opcode_e    opcode;  // Bits 14:8
    logic [7:0] imm;     // Immediate or jump target
  } instr_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_NOT = 3'd4,
    ALU_XOR = 3'd5,
    ALU_SHL = 3'd6,
    ALU_SHR = 3'd7
  } alu_op_e;

  // ALU left operand
  typedef enum logic [1:0] {
    SRC_A_REG  = 2'd0,
    SRC_A_ZERO = 2'd1
  } src_a_e;

  // ALU right operand
  typedef enum logic [1:0] {
    SRC_B_REG  = 2'd0,
    SRC_B_RAM  = 2'd1,
    SRC_B_IMM  = 2'd2,
    SRC_B_ZERO = 2'd3
  } src_b_e;

  typedef struct packed {
    alu_op_e alu_op;
    src_a_e  src_a;
    src_b_e  src_b;
    logic    load_a;    // Write result to A
    logic    load_b;    // Write result to B
    logic    flags_en;  // Latch next flags
    logic    ram_we;    // Store result at address B
    logic    jump;      // Resolved jump, PC takes imm
  } ctrl_t;

endpackage

//--- logic/program_rom.sv
module program_rom import core_pkg::*, isa_pkg::*; (
  input  rom_addr_t addr,
  output instr_t    instr
);

  // Fixed test program, touches every opcode
  always_comb begin
    case (addr)
      8'd0:    instr = '{LDB_IMM, 8'd5};    // B = 5, RAM address
      8'd1:    instr = '{LDA_IMM, 8'd3};
      8'd2:    instr = '{ADD,     8'd0};    // 8
      8'd3:    instr = '{SUB,     8'd0};    // 3
      8'd4:    instr = '{ST,      8'd0};    // mem[5] = 3
      8'd5:    instr = '{LDA_IMM, 8'd0};
      8'd6:    instr = '{LD,      8'd0};    // A back to 3
      8'd7:    instr = '{XOR,     8'd0};    // 6
      8'd8:    instr = '{SHL,     8'd0};    // 12
      8'd9:    instr = '{NOT,     8'd0};    // 243
      8'd10:   instr = '{AND,     8'd0};    // 1
      8'd11:   instr = '{OR,      8'd0};    // 5
      8'd12:   instr = '{SHR,     8'd0};    // 2
      8'd13:   instr = '{LDB_IMM, 8'd2};
      8'd14:   instr = '{SUB,     8'd0};    // 0, sets Z
      8'd15:   instr = '{JNZ,     8'd0};    // Falls through
      8'd16:   instr = '{JZ,      8'd18};
      8'd17:   instr = '{LDA_IMM, 8'd255};  // Skipped marker
      8'd18:   instr = '{SUB,     8'd0};    // 254, sets N and C
      8'd19:   instr = '{JN,      8'd21};
      8'd20:   instr = '{LDA_IMM, 8'd255};  // Skipped marker
      8'd21:   instr = '{JC,      8'd23};
      8'd22:   instr = '{LDA_IMM, 8'd255};  // Skipped marker
      8'd23:   instr = '{JMP,     8'd0};    // Restart
      default: instr = '{NOP,     8'd0};
    endcase
  end

endmodule

//--- src.f
logic/core_pkg.sv
logic/isa_pkg.sv
logic/program_rom.sv
logic/cpu_decode.sv
logic/cpu_execute.sv
logic/data_ram.sv
logic/cpu_writeback.sv
logic/cpu_top.sv
test/tb_cpu_top.sv

//--- test/tb_cpu_top.sv
module tb_cpu_top import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 10;
  localparam int TBL_LEN         = 21;               // One pass, PC 0 back to PC 0
  localparam int STEPS_RUN       = 4 * TBL_LEN;      // Two passes, partial pass, rerun
  localparam int CYCLES_PER_STEP = 10;               // ALU read, strobe, idle, 3 reads
  localparam int WATCHDOG_CYCLES = STEPS_RUN * CYCLES_PER_STEP + 100;

  // Expected state around one step
  typedef struct packed {
    data_t     alu;     // ALU view before the step
    logic      a_kept;  // A not written, keeps previous value
    rom_addr_t pc;      // PC after the step
    data_t     a;       // A after the step
    data_t     b;       // B after the step
  } step_exp_t;

  logic  clk = 1'b0;
  logic  rst;
  logic  step;
  view_e view;
  data_t display;

  step_exp_t   tbl [TBL_LEN];
  data_t       a_prev;                 // Running expected A
  logic [31:0] rng_state = 32'h1535_b827;
  int          errors = 0;
  int          tests  = 0;
  int          failed = 0;

  cpu_top #(
    .RAM_DEPTH (32)
  ) u_cpu_top (
    .clk     (clk),
    .rst     (rst),
    .step    (step),
    .view    (view),
    .display (display)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic set_entry(input int idx, input data_t alu, input logic a_kept,
                           input rom_addr_t pc, input data_t a, input data_t b);
    tbl[idx] = '{alu, a_kept, pc, a, b};
  endtask

  // Hand-traced from the program, flags per the ALU rules
  task automatic fill_table();
    set_entry(0,  8'h05, 1'b1, 8'd1,  8'h00, 8'h05);  // LDB_IMM 5, A untouched
    set_entry(1,  8'h03, 1'b0, 8'd2,  8'h03, 8'h05);  // LDA_IMM 3
    set_entry(2,  8'h08, 1'b0, 8'd3,  8'h08, 8'h05);  // 3 + 5
    set_entry(3,  8'h03, 1'b0, 8'd4,  8'h03, 8'h05);  // 8 - 5
    set_entry(4,  8'h03, 1'b0, 8'd5,  8'h03, 8'h05);  // ST, mem[5] = 3
    set_entry(5,  8'h00, 1'b0, 8'd6,  8'h00, 8'h05);  // LDA_IMM 0
    set_entry(6,  8'h03, 1'b0, 8'd7,  8'h03, 8'h05);  // LD mem[5]
    set_entry(7,  8'h06, 1'b0, 8'd8,  8'h06, 8'h05);  // 3 ^ 5
    set_entry(8,  8'h0c, 1'b0, 8'd9,  8'h0c, 8'h05);  // SHL
    set_entry(9,  8'hf3, 1'b0, 8'd10, 8'hf3, 8'h05);  // NOT
    set_entry(10, 8'h01, 1'b0, 8'd11, 8'h01, 8'h05);  // f3 & 05
    set_entry(11, 8'h05, 1'b0, 8'd12, 8'h05, 8'h05);  // 01 | 05
    set_entry(12, 8'h02, 1'b0, 8'd13, 8'h02, 8'h05);  // SHR, C set
    set_entry(13, 8'h02, 1'b0, 8'd14, 8'h02, 8'h02);  // LDB_IMM 2
    set_entry(14, 8'h00, 1'b0, 8'd15, 8'h00, 8'h02);  // 2 - 2, Z set
    set_entry(15, 8'h00, 1'b0, 8'd16, 8'h00, 8'h02);  // JNZ falls through
    set_entry(16, 8'h00, 1'b0, 8'd18, 8'h00, 8'h02);  // JZ taken
    set_entry(17, 8'hfe, 1'b0, 8'd19, 8'hfe, 8'h02);  // 0 - 2, N and C set
    set_entry(18, 8'hfe, 1'b0, 8'd21, 8'hfe, 8'h02);  // JN taken
    set_entry(19, 8'hfe, 1'b0, 8'd23, 8'hfe, 8'h02);  // JC taken
    set_entry(20, 8'hfe, 1'b0, 8'd0,  8'hfe, 8'h02);  // JMP 0
  endtask

  task automatic compare_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    if (errors != errs_before) begin
      failed++;
      $display("%s: FAIL", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // Sample 1 ns after the falling edge, far from any clock edge
  task automatic read_view(input view_e v, output data_t val);
    @(negedge clk);
    view = v;
    #1;
    val = display;
  endtask

  task automatic pulse_step();
    @(negedge clk);
    step = 1'b1;
    @(negedge clk);
    step = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    a_prev = '0;
  endtask

  // Zero state, ALU shows LDB_IMM 5 at PC 0
  task automatic check_reset_state(input string name);
    data_t got;
    int    errs_before;
    errs_before = errors;
    read_view(VIEW_PC, got);
    compare_addr("pc", rom_addr_t'(got), '0);
    read_view(VIEW_A, got);
    compare_data("reg_a", got, '0);
    read_view(VIEW_B, got);
    compare_data("reg_b", got, '0);
    read_view(VIEW_ALU, got);
    compare_data("alu_view", got, tbl[0].alu);
    finish_test(name, errs_before);
  endtask

  task automatic apply_step(input int idx);
    step_exp_t e;
    data_t     got;
    data_t     exp_a;
    int        errs_before;
    e           = tbl[idx];
    errs_before = errors;
    read_view(VIEW_ALU, got);
    compare_data("alu_view", got, e.alu);
    pulse_step();
    rng_state = xorshift32(rng_state);
    repeat (rng_state[1:0]) @(negedge clk);  // 0 to 3 idle cycles
    exp_a  = e.a_kept ? a_prev : e.a;
    a_prev = exp_a;
    read_view(VIEW_PC, got);
    compare_addr("pc", rom_addr_t'(got), e.pc);
    read_view(VIEW_A, got);
    compare_data("reg_a", got, exp_a);
    read_view(VIEW_B, got);
    compare_data("reg_b", got, e.b);
    finish_test($sformatf("step %0d", idx), errs_before);
  endtask

  task automatic run_steps(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      apply_step(i);
    end
  endtask

  // B = 5 here, so this is the byte LD would fetch
  task automatic check_ram_cleared();
    int errs_before;
    errs_before = errors;
    @(negedge clk);
    #1;
    compare_data("ram_rdata", u_cpu_top.ram_rdata, '0);
    finish_test("ram cleared", errs_before);
  endtask

  initial begin
    rst    = 1'b1;
    step   = 1'b0;
    view   = VIEW_PC;
    a_prev = '0;
    fill_table();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    check_reset_state("reset");
    run_steps(0, TBL_LEN - 1);  // First pass
    run_steps(0, TBL_LEN - 1);  // Second pass after JMP 0
    run_steps(0, 8);            // Stop mid-program, mem[5] holds 3
    apply_reset();
    check_reset_state("mid reset");
    run_steps(0, 3);            // Up to ST, not through it
    check_ram_cleared();
    run_steps(4, TBL_LEN - 1);
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Budget covers every step with full idle gaps
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
